// ==== design/ccu_pkg.sv ====
// Shared sizes, opcodes, state codes and instruction word views for the CCU.
// Every design file refers to these by scoped name, for example ccu_pkg::OP_CONV.
package ccu_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int ISA_WORD_W = 96;
    localparam int ISA_ADDR_W = 4;
    localparam int ISA_DEPTH  = 16;
    // Extra MSB marks a wrap
    localparam int PTR_W      = ISA_ADDR_W + 1;
    localparam int OPC_W      = 3;
    localparam int WIDX_W     = 2;
    localparam int ST_W       = 3;

    // Opcodes, low 3 bits of a layer's first word
    localparam logic [OPC_W-1:0] OP_ARRAY = 3'd0;
    localparam logic [OPC_W-1:0] OP_CONV  = 3'd1;
    localparam logic [OPC_W-1:0] OP_FC    = 3'd2;
    localparam logic [OPC_W-1:0] OP_POOL  = 3'd3;

    // Words per layer
    localparam logic [WIDX_W-1:0] WORDS_CONV = 2'd2;
    localparam logic [WIDX_W-1:0] WORDS_ONE  = 2'd1;

    // Controller FSM codes
    localparam logic [ST_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [ST_W-1:0] ST_ARRAY_CFG = 3'd1;
    localparam logic [ST_W-1:0] ST_LY_CFG    = 3'd2;
    localparam logic [ST_W-1:0] ST_LY_ISSUE  = 3'd3;
    localparam logic [ST_W-1:0] ST_LY_WORK   = 3'd4;
    localparam logic [ST_W-1:0] ST_FNH       = 3'd5;

    // ============================================================
    // Instruction word views, MSB first
    // ============================================================
    typedef struct packed {
        logic [52:0]      pad;
        logic [7:0]       ly_num;
        logic [31:0]      base_addr;
        logic [OPC_W-1:0] opcode;
    } array_view_t;

    // CONV word 0 (ch is chi) and FC (ch is cho)
    typedef struct packed {
        logic             pad;
        logic [11:0]      ch;
        logic [15:0]      nip;
        logic [31:0]      wgt_addr;
        logic [31:0]      dat_addr;
        logic [OPC_W-1:0] opcode;
    } layer_view_t;

    typedef struct packed {
        logic [36:0]      pad;
        logic [7:0]       pool_k;
        logic [15:0]      nip;
        logic [31:0]      dat_addr;
        logic [OPC_W-1:0] opcode;
    } pool_view_t;

    // CONV word 1, carries no opcode
    typedef struct packed {
        logic [45:0] pad;
        logic [1:0]  mode;
        logic [7:0]  zp;
        logic [7:0]  shift;
        logic [19:0] scale;
        logic [11:0] cho;
    } quant_view_t;

    typedef union packed {
        array_view_t arr;
        layer_view_t ly;
        pool_view_t  pool;
        quant_view_t quant;
    } cfg_word_u;

endpackage

// ==== design/isa_ram.sv ====
// Instruction buffer for the CCU, one write port and one synchronous read port.
// Read data appears the cycle after rd_en.
module isa_ram (
    input  logic                           clk,
    input  logic                           we,
    input  logic [ccu_pkg::ISA_ADDR_W-1:0] wr_addr,
    input  logic [ccu_pkg::ISA_WORD_W-1:0] wr_data,
    input  logic                           rd_en,
    input  logic [ccu_pkg::ISA_ADDR_W-1:0] rd_addr,
    output logic [ccu_pkg::ISA_WORD_W-1:0] rd_data
);

    // Storage array, contents undefined until written
    logic [ccu_pkg::ISA_WORD_W-1:0] mem [ccu_pkg::ISA_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, holds last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== design/cfg_decode.sv ====
// Turns instruction words from the buffer into registered layer configuration.
// Counts words per layer and raises ly_ready on the last word of each layer.
// Fields not defined by the current opcode are cleared to 0.
module cfg_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_data_vld,
    input  ccu_pkg::cfg_word_u        rd_data,
    output logic                      ly_ready,
    output logic [ccu_pkg::OPC_W-1:0] op,
    output logic [7:0]                ly_num,
    output logic [31:0]               base_addr,
    output logic [31:0]               dat_addr,
    output logic [31:0]               wgt_addr,
    output logic [15:0]               nip,
    output logic [11:0]               chi,
    output logic [11:0]               cho,
    output logic [7:0]                pool_k,
    output logic [7:0]                sya_shift,
    output logic [7:0]                sya_zp,
    output logic [19:0]               sya_scale,
    output logic [1:0]                sya_mode
);

    logic [ccu_pkg::WIDX_W-1:0] word_idx;
    logic [ccu_pkg::WIDX_W-1:0] n_words;
    logic [ccu_pkg::OPC_W-1:0]  cur_opc;
    logic                       first_word;

    // ============================================================
    // Word counting
    // ============================================================
    assign first_word = (word_idx == '0);
    // Opcode comes from the word itself only on the first word
    assign cur_opc    = first_word ? rd_data.arr.opcode : op;
    assign n_words    = (cur_opc == ccu_pkg::OP_CONV) ? ccu_pkg::WORDS_CONV : ccu_pkg::WORDS_ONE;
    assign ly_ready   = rd_data_vld && (word_idx == n_words - 2'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx <= '0;
            op       <= '0;
        end else if (rd_data_vld) begin
            // Wrap to 0 after the layer's last word
            word_idx <= ly_ready ? '0 : word_idx + 2'd1;
            if (first_word) begin
                op <= cur_opc;
            end
        end
    end

    // ============================================================
    // Field registers
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ly_num    <= '0;
            base_addr <= '0;
            dat_addr  <= '0;
            wgt_addr  <= '0;
            nip       <= '0;
            chi       <= '0;
            cho       <= '0;
            pool_k    <= '0;
            sya_shift <= '0;
            sya_zp    <= '0;
            sya_scale <= '0;
            sya_mode  <= '0;
        end else if (rd_data_vld && first_word) begin
            case (rd_data.arr.opcode)
                // Program header, layer fields untouched
                ccu_pkg::OP_ARRAY: begin
                    base_addr <= rd_data.arr.base_addr;
                    ly_num    <= rd_data.arr.ly_num;
                end
                // Quant fields and cho follow in word 1
                ccu_pkg::OP_CONV: begin
                    dat_addr <= rd_data.ly.dat_addr;
                    wgt_addr <= rd_data.ly.wgt_addr;
                    nip      <= rd_data.ly.nip;
                    chi      <= rd_data.ly.ch;
                    pool_k   <= '0;
                end
                ccu_pkg::OP_FC: begin
                    dat_addr  <= rd_data.ly.dat_addr;
                    wgt_addr  <= rd_data.ly.wgt_addr;
                    nip       <= rd_data.ly.nip;
                    cho       <= rd_data.ly.ch;
                    chi       <= '0;
                    pool_k    <= '0;
                    sya_shift <= '0;
                    sya_zp    <= '0;
                    sya_scale <= '0;
                    sya_mode  <= '0;
                end
                ccu_pkg::OP_POOL: begin
                    dat_addr  <= rd_data.pool.dat_addr;
                    nip       <= rd_data.pool.nip;
                    pool_k    <= rd_data.pool.pool_k;
                    wgt_addr  <= '0;
                    chi       <= '0;
                    cho       <= '0;
                    sya_shift <= '0;
                    sya_zp    <= '0;
                    sya_scale <= '0;
                    sya_mode  <= '0;
                end
                // Unknown opcode, nothing loaded
                default: ;
            endcase
        end else if (rd_data_vld) begin
            // CONV word 1
            cho       <= rd_data.quant.cho;
            sya_scale <= rd_data.quant.scale;
            sya_shift <= rd_data.quant.shift;
            sya_zp    <= rd_data.quant.zp;
            sya_mode  <= rd_data.quant.mode;
        end
    end

endmodule

// ==== design/ccu_ctrl.sv ====
// CCU controller: main FSM, buffer pointers and single in-flight read issue.
// Offers each decoded layer to the GLB over cfg_vld/cfg_rdy and generates
// port_rst, sya_start and done.
module ccu_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           dat_vld,
    output logic                           dat_rdy,
    output logic                           we,
    output logic [ccu_pkg::ISA_ADDR_W-1:0] wr_addr,
    output logic                           rd_en,
    output logic [ccu_pkg::ISA_ADDR_W-1:0] rd_addr,
    output logic                           rd_data_vld,
    input  logic                           ly_ready,
    input  logic [ccu_pkg::OPC_W-1:0]      op,
    input  logic [7:0]                     ly_num,
    output logic                           cfg_vld,
    input  logic                           cfg_rdy,
    output logic                           port_rst,
    output logic                           sya_start,
    input  logic                           port_fnh,
    output logic                           done
);

    logic [ccu_pkg::ST_W-1:0]  state;
    logic [ccu_pkg::ST_W-1:0]  next_state;
    logic [ccu_pkg::PTR_W-1:0] wr_ptr;
    logic [ccu_pkg::PTR_W-1:0] rd_ptr;
    logic                      full;
    logic                      empty;
    logic                      want_rd;
    logic                      cfg_acc;
    logic                      arr_done;
    logic [7:0]                ly_left;
    logic [7:0]                ly_left_cur;

    // ============================================================
    // Buffer pointers
    // ============================================================
    // Same index with opposite wrap bit means full
    assign full    = (wr_ptr[ccu_pkg::ISA_ADDR_W] != rd_ptr[ccu_pkg::ISA_ADDR_W]) &&
                     (wr_ptr[ccu_pkg::ISA_ADDR_W-1:0] == rd_ptr[ccu_pkg::ISA_ADDR_W-1:0]);
    assign empty   = (wr_ptr == rd_ptr);
    assign dat_rdy = !full;
    assign we      = dat_vld && dat_rdy;
    assign wr_addr = wr_ptr[ccu_pkg::ISA_ADDR_W-1:0];
    assign rd_addr = rd_ptr[ccu_pkg::ISA_ADDR_W-1:0];

    // Reads only while collecting words, one at a time
    assign want_rd = (state == ccu_pkg::ST_ARRAY_CFG) || (state == ccu_pkg::ST_LY_CFG) ||
                     ((state == ccu_pkg::ST_FNH) && (ly_left_cur != 8'd0));
    assign rd_en   = want_rd && !empty && !rd_data_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            rd_data_vld <= 1'b0;
        end else begin
            if (we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Buffer data lands one cycle after the read
            rd_data_vld <= rd_en;
        end
    end

    // ============================================================
    // FSM
    // ============================================================
    assign cfg_vld     = (state == ccu_pkg::ST_LY_ISSUE);
    assign cfg_acc     = cfg_vld && cfg_rdy;
    // ly_num is registered by the decoder, so take it one cycle after the ARRAY word
    assign ly_left_cur = arr_done ? ly_num : ly_left;
    assign done        = (state == ccu_pkg::ST_FNH) && (ly_left_cur == 8'd0);

    always_comb begin
        next_state = state;
        case (state)
            ccu_pkg::ST_IDLE:      if (start) next_state = ccu_pkg::ST_ARRAY_CFG;
            ccu_pkg::ST_ARRAY_CFG: if (ly_ready) next_state = ccu_pkg::ST_FNH;
            ccu_pkg::ST_LY_CFG:    if (ly_ready) next_state = ccu_pkg::ST_LY_ISSUE;
            ccu_pkg::ST_LY_ISSUE:  if (cfg_rdy) next_state = ccu_pkg::ST_LY_WORK;
            ccu_pkg::ST_LY_WORK:   if (port_fnh) next_state = ccu_pkg::ST_FNH;
            // Decide between next layer and end of program
            ccu_pkg::ST_FNH: begin
                if (ly_left_cur == 8'd0) begin
                    next_state = ccu_pkg::ST_IDLE;
                end else begin
                    next_state = ccu_pkg::ST_LY_CFG;
                end
            end
            default:               next_state = ccu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ccu_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ============================================================
    // Layer counting and pulses
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arr_done  <= 1'b0;
            ly_left   <= '0;
            port_rst  <= 1'b0;
            sya_start <= 1'b0;
        end else begin
            arr_done <= (state == ccu_pkg::ST_ARRAY_CFG) && ly_ready;
            // One count per layer started
            if ((state == ccu_pkg::ST_FNH) && (ly_left_cur != 8'd0)) begin
                ly_left <= ly_left_cur - 8'd1;
            end
            port_rst  <= cfg_acc;
            // Systolic array runs only for compute layers
            sya_start <= cfg_acc && ((op == ccu_pkg::OP_CONV) || (op == ccu_pkg::OP_FC));
        end
    end

endmodule

// ==== design/ccu_sys.sv ====
// CCU top level: controller, instruction buffer and configuration decoder.
// Host writes words on dat/dat_vld/dat_rdy, GLB takes layers on cfg_vld/cfg_rdy.
module ccu_sys (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [ccu_pkg::ISA_WORD_W-1:0] dat,
    input  logic                           dat_vld,
    output logic                           dat_rdy,
    output logic                           cfg_vld,
    input  logic                           cfg_rdy,
    output logic [ccu_pkg::OPC_W-1:0]      op,
    output logic [31:0]                    base_addr,
    output logic [31:0]                    dat_addr,
    output logic [31:0]                    wgt_addr,
    output logic [15:0]                    nip,
    output logic [11:0]                    chi,
    output logic [11:0]                    cho,
    output logic [7:0]                     pool_k,
    output logic [7:0]                     sya_shift,
    output logic [7:0]                     sya_zp,
    output logic [19:0]                    sya_scale,
    output logic [1:0]                     sya_mode,
    output logic                           sya_start,
    output logic                           port_rst,
    input  logic                           port_fnh,
    output logic                           done
);

    // Buffer side
    logic                           we;
    logic [ccu_pkg::ISA_ADDR_W-1:0] wr_addr;
    logic                           rd_en;
    logic [ccu_pkg::ISA_ADDR_W-1:0] rd_addr;
    logic [ccu_pkg::ISA_WORD_W-1:0] rd_data;
    logic                           rd_data_vld;
    // Decoder status
    logic                           ly_ready;
    logic [7:0]                     ly_num;

    ccu_ctrl u_ccu_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .dat_vld     (dat_vld),
        .dat_rdy     (dat_rdy),
        .we          (we),
        .wr_addr     (wr_addr),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data_vld (rd_data_vld),
        .ly_ready    (ly_ready),
        .op          (op),
        .ly_num      (ly_num),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .port_rst    (port_rst),
        .sya_start   (sya_start),
        .port_fnh    (port_fnh),
        .done        (done)
    );

    isa_ram u_isa_ram (
        .clk     (clk),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_data (dat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cfg_decode u_cfg_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_data_vld (rd_data_vld),
        .rd_data     (rd_data),
        .ly_ready    (ly_ready),
        .op          (op),
        .ly_num      (ly_num),
        .base_addr   (base_addr),
        .dat_addr    (dat_addr),
        .wgt_addr    (wgt_addr),
        .nip         (nip),
        .chi         (chi),
        .cho         (cho),
        .pool_k      (pool_k),
        .sya_shift   (sya_shift),
        .sya_zp      (sya_zp),
        .sya_scale   (sya_scale),
        .sya_mode    (sya_mode)
    );

endmodule

// ==== bench/ccu_sys_asserts.sv ====
// Protocol assertions on the CCU controller.
// Bound into ccu_ctrl from the testbench top.
module ccu_sys_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      cfg_vld,
    input logic                      cfg_rdy,
    input logic [ccu_pkg::OPC_W-1:0] op,
    input logic                      port_rst,
    input logic                      done,
    input logic                      dat_rdy,
    input logic                      we,
    input logic                      rd_en
);

    int assert_errs = 0;
    // Words held in the buffer, counted from write and read strobes
    logic [ccu_pkg::PTR_W-1:0] fill;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else if (we && !rd_en) begin
            fill <= fill + 1'b1;
        end else if (rd_en && !we) begin
            fill <= fill - 1'b1;
        end
    end

    // Offer and opcode hold under back-pressure
    a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_vld && !cfg_rdy |=> cfg_vld && $stable(op))
        else begin
            assert_errs++;
            $error("cfg_vld dropped or op changed before cfg_rdy");
        end

    // GLB port reset one cycle after acceptance, offer withdrawn by then
    a_port_rst: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_vld && cfg_rdy |=> port_rst && !cfg_vld)
        else begin
            assert_errs++;
            $error("port_rst missing or cfg_vld still high one cycle after cfg acceptance");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            assert_errs++;
            $error("done held longer than one cycle");
        end

    // Sixteen words stored sets the top bit of the count
    a_full_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        fill[ccu_pkg::ISA_ADDR_W] |-> !dat_rdy)
        else begin
            assert_errs++;
            $error("dat_rdy high while the buffer is full");
        end

endmodule

// ==== bench/tb_ccu_sys.sv ====
// Directed testbench for the CCU top level.
// Loads instruction programs into the buffer, plays the GLB side of the
// cfg handshake and checks decoded layer fields, pulses and buffer flow.
module tb_ccu_sys;

    localparam int TIMEOUT_CYCLES = 6 * 600;

    // Expected layer configuration, undefined fields kept at 0
    typedef struct packed {
        logic [ccu_pkg::OPC_W-1:0] op;
        logic [31:0]               dat_addr;
        logic [31:0]               wgt_addr;
        logic [15:0]               nip;
        logic [11:0]               chi;
        logic [11:0]               cho;
        logic [7:0]                pool_k;
        logic [7:0]                shift;
        logic [7:0]                zp;
        logic [19:0]               scale;
        logic [1:0]                mode;
    } layer_t;

    logic                           clk;
    logic                           rst_n;
    logic                           start;
    logic [ccu_pkg::ISA_WORD_W-1:0] dat;
    logic                           dat_vld;
    logic                           dat_rdy;
    logic                           cfg_vld;
    logic                           cfg_rdy;
    logic [ccu_pkg::OPC_W-1:0]      op;
    logic [31:0]                    base_addr;
    logic [31:0]                    dat_addr;
    logic [31:0]                    wgt_addr;
    logic [15:0]                    nip;
    logic [11:0]                    chi;
    logic [11:0]                    cho;
    logic [7:0]                     pool_k;
    logic [7:0]                     sya_shift;
    logic [7:0]                     sya_zp;
    logic [19:0]                    sya_scale;
    logic [1:0]                     sya_mode;
    logic                           sya_start;
    logic                           port_rst;
    logic                           port_fnh;
    logic                           done;

    int     errors = 0;
    int     cycles = 0;
    int     n_port_rst = 0;
    int     n_sya = 0;
    int     n_done = 0;
    int     total;
    logic [31:0] base_exp;
    // Layers of the program under test, in order
    layer_t prog[$];

    ccu_sys u_ccu_sys (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dat       (dat),
        .dat_vld   (dat_vld),
        .dat_rdy   (dat_rdy),
        .cfg_vld   (cfg_vld),
        .cfg_rdy   (cfg_rdy),
        .op        (op),
        .base_addr (base_addr),
        .dat_addr  (dat_addr),
        .wgt_addr  (wgt_addr),
        .nip       (nip),
        .chi       (chi),
        .cho       (cho),
        .pool_k    (pool_k),
        .sya_shift (sya_shift),
        .sya_zp    (sya_zp),
        .sya_scale (sya_scale),
        .sya_mode  (sya_mode),
        .sya_start (sya_start),
        .port_rst  (port_rst),
        .port_fnh  (port_fnh),
        .done      (done)
    );

    bind ccu_ctrl ccu_sys_asserts u_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg_rdy  (cfg_rdy),
        .op       (op),
        .port_rst (port_rst),
        .done     (done),
        .dat_rdy  (dat_rdy),
        .we       (we),
        .rd_en    (rd_en)
    );

    // ============================================================
    // Clock, watchdog and pulse counters
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Pulses sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (port_rst) n_port_rst++;
            if (sya_start) n_sya++;
            if (done) n_done++;
        end
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_word32(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    // Widest narrow port is sya_scale
    task automatic check_field(input string name, input logic [19:0] exp,
                               input logic [19:0] act);
        if (act !== exp) begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s expected %0b actual %0b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_layer(input string name, input layer_t e);
        check_field({name, " op"}, 20'(e.op), 20'(op));
        check_word32({name, " dat_addr"}, e.dat_addr, dat_addr);
        check_word32({name, " wgt_addr"}, e.wgt_addr, wgt_addr);
        check_field({name, " nip"}, 20'(e.nip), 20'(nip));
        check_field({name, " chi"}, 20'(e.chi), 20'(chi));
        check_field({name, " cho"}, 20'(e.cho), 20'(cho));
        check_field({name, " pool_k"}, 20'(e.pool_k), 20'(pool_k));
        check_field({name, " sya_shift"}, 20'(e.shift), 20'(sya_shift));
        check_field({name, " sya_zp"}, 20'(e.zp), 20'(sya_zp));
        check_field({name, " sya_scale"}, e.scale, sya_scale);
        check_field({name, " sya_mode"}, 20'(e.mode), 20'(sya_mode));
    endtask

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // Random values only in the fields the opcode defines
    function automatic layer_t build_layer(input logic [ccu_pkg::OPC_W-1:0] opc);
        layer_t l;
        l          = '0;
        l.op       = opc;
        l.dat_addr = $urandom();
        l.nip      = 16'($urandom());
        if (opc != ccu_pkg::OP_POOL) begin
            l.wgt_addr = $urandom();
            l.cho      = 12'($urandom());
        end
        if (opc == ccu_pkg::OP_POOL) begin
            l.pool_k = 8'($urandom());
        end
        if (opc == ccu_pkg::OP_CONV) begin
            l.chi   = 12'($urandom());
            l.scale = 20'($urandom());
            l.shift = 8'($urandom());
            l.zp    = 8'($urandom());
            l.mode  = 2'($urandom());
        end
        return l;
    endfunction

    // Host write, held until dat_rdy
    task automatic push_word(input ccu_pkg::cfg_word_u w);
        @(negedge clk);
        dat     = w;
        dat_vld = 1'b1;
        while (!dat_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        dat_vld = 1'b0;
    endtask

    task automatic push_array(input logic [31:0] base, input logic [7:0] n);
        ccu_pkg::cfg_word_u w;
        w               = '0;
        w.arr.opcode    = ccu_pkg::OP_ARRAY;
        w.arr.base_addr = base;
        w.arr.ly_num    = n;
        base_exp        = base;
        push_word(w);
    endtask

    task automatic load_layer(input layer_t l);
        ccu_pkg::cfg_word_u w;
        w = '0;
        if (l.op == ccu_pkg::OP_POOL) begin
            w.pool.opcode   = l.op;
            w.pool.dat_addr = l.dat_addr;
            w.pool.nip      = l.nip;
            w.pool.pool_k   = l.pool_k;
        end else begin
            w.ly.opcode   = l.op;
            w.ly.dat_addr = l.dat_addr;
            w.ly.wgt_addr = l.wgt_addr;
            w.ly.nip      = l.nip;
            // Channel slot is chi for CONV, cho for FC
            w.ly.ch       = (l.op == ccu_pkg::OP_CONV) ? l.chi : l.cho;
        end
        push_word(w);
        if (l.op == ccu_pkg::OP_CONV) begin
            w             = '0;
            w.quant.cho   = l.cho;
            w.quant.scale = l.scale;
            w.quant.shift = l.shift;
            w.quant.zp    = l.zp;
            w.quant.mode  = l.mode;
            push_word(w);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // GLB side of one layer: offer, optional stall, accept, finish
    task automatic serve_layer(input string name, input layer_t e, input bit last,
                               input bit stall);
        int stalls;
        int gap;
        @(negedge clk);
        while (!cfg_vld) begin
            @(negedge clk);
        end
        check_layer(name, e);
        stalls = stall ? $urandom_range(4, 1) : 0;
        repeat (stalls) begin
            @(negedge clk);
            check_pulse({name, " cfg_vld hold"}, 1'b1, cfg_vld);
            check_layer({name, " hold"}, e);
        end
        cfg_rdy = 1'b1;
        @(negedge clk);
        cfg_rdy = 1'b0;
        check_pulse({name, " port_rst"}, 1'b1, port_rst);
        check_pulse({name, " sya_start"},
                    (e.op == ccu_pkg::OP_CONV) || (e.op == ccu_pkg::OP_FC), sya_start);
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk);
        port_fnh = 1'b1;
        @(negedge clk);
        port_fnh = 1'b0;
        check_pulse({name, " done"}, last, done);
    endtask

    task automatic serve_all(input string name, input bit stall);
        int rst0;
        int sya0;
        int done0;
        int n_comp;
        rst0   = n_port_rst;
        sya0   = n_sya;
        done0  = n_done;
        n_comp = 0;
        foreach (prog[i]) begin
            if ((prog[i].op == ccu_pkg::OP_CONV) || (prog[i].op == ccu_pkg::OP_FC)) n_comp++;
            serve_layer(name, prog[i], i == prog.size() - 1, stall);
        end
        @(negedge clk);
        check_field({name, " port_rst count"}, 20'(prog.size()), 20'(n_port_rst - rst0));
        check_field({name, " sya_start count"}, 20'(n_comp), 20'(n_sya - sya0));
        check_field({name, " done count"}, 20'd1, 20'(n_done - done0));
        check_word32({name, " base_addr"}, base_exp, base_addr);
    endtask

    task automatic run_program(input string name, input bit stall);
        push_array($urandom(), 8'(prog.size()));
        foreach (prog[i]) begin
            load_layer(prog[i]);
        end
        pulse_start();
        serve_all(name, stall);
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_reset();
        check_pulse("reset dat_rdy", 1'b1, dat_rdy);
        check_pulse("reset cfg_vld", 1'b0, cfg_vld);
        check_pulse("reset port_rst", 1'b0, port_rst);
        check_pulse("reset sya_start", 1'b0, sya_start);
        check_pulse("reset done", 1'b0, done);
        check_word32("reset base_addr", 32'd0, base_addr);
        check_layer("reset", '0);
    endtask

    task automatic test_single_conv();
        prog.delete();
        prog.push_back(build_layer(ccu_pkg::OP_CONV));
        run_program("single_conv", 1'b0);
    endtask

    task automatic test_mixed_stall();
        prog.delete();
        prog.push_back(build_layer(ccu_pkg::OP_FC));
        prog.push_back(build_layer(ccu_pkg::OP_POOL));
        prog.push_back(build_layer(ccu_pkg::OP_CONV));
        prog.push_back(build_layer(ccu_pkg::OP_FC));
        prog.push_back(build_layer(ccu_pkg::OP_POOL));
        prog.push_back(build_layer(ccu_pkg::OP_CONV));
        run_program("mixed_stall", 1'b1);
    endtask

    // Two pool layers, so sya_start lags port_rst by two pulses
    task automatic test_pulse_count();
        prog.delete();
        prog.push_back(build_layer(ccu_pkg::OP_POOL));
        prog.push_back(build_layer(ccu_pkg::OP_CONV));
        prog.push_back(build_layer(ccu_pkg::OP_POOL));
        prog.push_back(build_layer(ccu_pkg::OP_FC));
        run_program("pulse_count", 1'b0);
    endtask

    task automatic test_full_buffer();
        layer_t l;
        prog.delete();
        push_array($urandom(), 8'd16);
        for (int i = 0; i < 15; i++) begin
            l = build_layer((i % 2) ? ccu_pkg::OP_POOL : ccu_pkg::OP_FC);
            prog.push_back(l);
            load_layer(l);
        end
        // Sixteen words stored
        check_pulse("full_buffer dat_rdy when full", 1'b0, dat_rdy);
        pulse_start();
        while (!dat_rdy) begin
            @(negedge clk);
        end
        // Single-word layer lands in the freed slot
        l = build_layer(ccu_pkg::OP_FC);
        prog.push_back(l);
        load_layer(l);
        serve_all("full_buffer", 1'b0);
    endtask

    task automatic test_zero_layers();
        int done0;
        prog.delete();
        push_array($urandom(), 8'd0);
        done0 = n_done;
        pulse_start();
        while (!done) begin
            check_pulse("zero_layers cfg_vld", 1'b0, cfg_vld);
            @(negedge clk);
        end
        @(negedge clk);
        check_field("zero_layers done count", 20'd1, 20'(n_done - done0));
        check_word32("zero_layers base_addr", base_exp, base_addr);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        void'($urandom(59));
        rst_n    = 1'b0;
        start    = 1'b0;
        dat      = '0;
        dat_vld  = 1'b0;
        cfg_rdy  = 1'b0;
        port_fnh = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_single_conv();
        test_mixed_stall();
        test_pulse_count();
        test_full_buffer();
        test_zero_layers();
        @(negedge clk);
        total = errors + u_ccu_sys.u_ccu_ctrl.u_asserts.assert_errs;
        $display("Errors: %0d check, %0d assertion", errors,
                 u_ccu_sys.u_ccu_ctrl.u_asserts.assert_errs);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== ccu_sys.f ====
design/ccu_pkg.sv
design/isa_ram.sv
design/cfg_decode.sv
design/ccu_ctrl.sv
design/ccu_sys.sv
bench/ccu_sys_asserts.sv
bench/tb_ccu_sys.sv

// ==== Bender.yml ====
package:
  name: ccu_sys

sources:
  - files:
      - design/ccu_pkg.sv
      - design/isa_ram.sv
      - design/cfg_decode.sv
      - design/ccu_ctrl.sv
      - design/ccu_sys.sv
  - target: test
    files:
      - bench/ccu_sys_asserts.sv
      - bench/tb_ccu_sys.sv
